/* rtl/host_pkg.sv */
package host_pkg;

  typedef logic [23:0] sw_word_t;    // Host write word, bytes 2 to 0 of the bus word
  typedef logic [31:0] read_word_t;  // Read data and status word

  // --------------------
  // Status word bit positions
  localparam int st_w_reset      = 0;   // Set by reset itself
  localparam int st_w_cfg_static = 1;
  localparam int st_r_cfg_static = 2;
  localparam int st_w_cfg_array  = 3;
  localparam int st_r_cfg_array  = 4;
  localparam int st_r_data_array = 5;
  localparam int st_w_execute    = 6;
  localparam int st_done         = 12;  // Follows the sequencer done state
  localparam int st_error        = 31;  // Bad execute settings

  // --------------------
  // Static register fields
  localparam int static_period_lsb = 0;  // Config clock period, bits 0 to 6
  localparam int static_sps_bit    = 7;  // Super-pixel select
  // Bits 8 to 23 are spare

  // Address-carrying writes
  localparam int addr_lsb = 16;
  localparam int addr_msb = 23;
  localparam int data_lsb = 0;
  localparam int data_msb = 15;

endpackage

/* rtl/chain_pkg.sv */
package chain_pkg;

  // Sequencer states
  typedef enum logic [2:0] {
    s_idle       = 3'd0,  // Nothing run since reset
    s_delay      = 3'd1,  // Align to the start of a config period
    s_reset_not  = 3'd2,  // Chip reset pulse, one full period
    s_shift_in_0 = 3'd3,  // First bit on the chain
    s_shift_in   = 3'd4,  // Remaining bits
    s_done       = 3'd5   // Holds until the next start
  } seq_state_t;

  // --------------------
  // Execute word fields
  localparam int field_width   = 7;   // Width of delay and sample settings
  localparam int ex_delay_lsb  = 0;   // Shift point in the period, bits 0 to 6
  localparam int ex_sample_lsb = 7;   // Sample point, bits 7 to 13
  localparam int ex_number_lsb = 14;
  localparam int ex_number_msb = 17;
  localparam int ex_loopback   = 18;  // Capture own bits instead of the chip
  localparam int ex_mask_rst   = 23;  // Keep reset_not high in the reset phase

  // Shift point must leave the sequencer a few cycles after the period start
  localparam logic [field_width-1:0] min_delay = 7'd3;

  // Only test 1, the chain load and readback
  localparam logic [3:0] chain_test_number = 4'd1;

endpackage

/* rtl/host_regs.sv */
`timescale 1ns/1ps

module host_regs
  import host_pkg::*;
#(
  parameter int cfg_words    = 8,
  parameter int period_width = 7
) (
  input  logic                       fw_axi_clk,
  input  logic                       op_code_w_reset,       // Sync reset, also a status op-code
  input  logic                       dev_id_enable,         // Device select for all op-codes
  input  logic                       op_code_w_cfg_static,
  input  logic                       op_code_r_cfg_static,
  input  logic                       op_code_w_cfg_array,
  input  logic                       op_code_r_cfg_array,
  input  logic                       op_code_r_data_array,
  input  logic                       op_code_w_status_clear,
  input  logic                       op_code_w_execute,
  input  sw_word_t                   sw_write24,            // Valid during the strobe
  input  logic                       seq_done,
  input  logic                       seq_error,
  input  logic [16*cfg_words-1:0]    capture_bits,
  output read_word_t                 read_data32,
  output read_word_t                 read_status32,
  output logic                       exec_strobe,
  output sw_word_t                   exec_word,
  output logic [period_width-1:0]    static_period,
  output logic                       super_pixel_sel,
  output logic [cfg_words-1:0][15:0] cfg_array
);

  // --------------------
  // Op-code gating
  logic w_static;
  logic r_static;
  logic w_array;
  logic r_array;
  logic r_data;
  logic w_clear;

  assign w_static    = op_code_w_cfg_static & dev_id_enable;
  assign r_static    = op_code_r_cfg_static & dev_id_enable;
  assign w_array     = op_code_w_cfg_array & dev_id_enable;
  assign r_array     = op_code_r_cfg_array & dev_id_enable;
  assign r_data      = op_code_r_data_array & dev_id_enable;
  assign w_clear     = op_code_w_status_clear & dev_id_enable;
  assign exec_strobe = op_code_w_execute & dev_id_enable;
  assign exec_word   = sw_write24;  // Sequencer decodes the fields itself

  logic [7:0]  addr;
  logic [15:0] wdata;
  assign addr  = sw_write24[addr_msb:addr_lsb];
  assign wdata = sw_write24[data_msb:data_lsb];

  sw_word_t static_reg;
  assign static_period   = static_reg[static_period_lsb +: period_width];
  assign super_pixel_sel = static_reg[static_sps_bit];

  // --------------------
  // Configuration writes
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      static_reg <= '0;
      cfg_array  <= '0;
    end else begin
      if (w_static)
        static_reg <= sw_write24;
      if (w_array) begin
        for (int i = 0; i < cfg_words; i++) begin
          if (addr == 8'(i))
            cfg_array[i] <= wdata;  // Writes past the array are dropped
        end
      end
    end
  end

  // Array word lookup, zero past the last word
  function automatic logic [15:0] array_word(input logic [8:0] idx);
    logic [15:0] w;
    w = '0;
    for (int i = 0; i < cfg_words; i++) begin
      if (idx == 9'(i))
        w = cfg_array[i];
    end
    return w;
  endfunction

  logic [cfg_words/2-1:0][31:0] capture_words;  // Readback as 32-bit words
  assign capture_words = capture_bits;

  // --------------------
  // Read multiplexer
  read_word_t read_next;
  always_comb begin
    read_next = '0;
    if (r_static) begin
      read_next = {8'h00, static_reg};
    end else if (r_array) begin
      read_next = {array_word({1'b0, addr} + 9'd1), array_word({1'b0, addr})};  // Pair a+1, a
    end else if (r_data) begin
      for (int i = 0; i < cfg_words / 2; i++) begin
        if (addr == 8'(i))
          read_next = capture_words[i];
      end
    end
  end

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset)
      read_data32 <= '0;
    else if (r_static | r_array | r_data)
      read_data32 <= read_next;  // Holds until the next read
  end

  // --------------------
  // Status word, op-code bits are sticky
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      read_status32             <= '0;
      read_status32[st_w_reset] <= 1'b1;
    end else if (w_clear) begin
      read_status32 <= '0;
    end else begin
      if (w_static)
        read_status32[st_w_cfg_static] <= 1'b1;
      if (r_static)
        read_status32[st_r_cfg_static] <= 1'b1;
      if (w_array)
        read_status32[st_w_cfg_array] <= 1'b1;
      if (r_array)
        read_status32[st_r_cfg_array] <= 1'b1;
      if (r_data)
        read_status32[st_r_data_array] <= 1'b1;
      if (exec_strobe)
        read_status32[st_w_execute] <= 1'b1;
      read_status32[st_done]  <= seq_done;   // One cycle behind the sequencer
      read_status32[st_error] <= seq_error;
    end
  end

endmodule

/* rtl/config_clk_gen.sv */
`timescale 1ns/1ps

module config_clk_gen #(
  parameter int period_width = 7
) (
  input  logic                    fw_axi_clk,
  input  logic                    op_code_w_reset,
  input  logic                    enable,       // Counter and clock freeze when low
  input  logic [period_width-1:0] period,
  output logic [period_width-1:0] clk_counter,  // Phase inside the period
  output logic                    config_clk
);

  // One config period is period+1 system cycles
  // Exported phase counter places the shift and sample points
  logic [period_width-1:0] count_next;

  // Wrap at the period even when it was lowered mid-count
  assign count_next = (clk_counter >= period) ? '0 : clk_counter + 1'b1;

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      clk_counter <= '0;
      config_clk  <= 1'b0;
    end else if (enable) begin
      clk_counter <= count_next;
      config_clk  <= count_next > (period >> 1);  // High in the second half
    end
  end

endmodule

/* rtl/chain_sequencer.sv */
`timescale 1ns/1ps

module chain_sequencer
  import host_pkg::*;
  import chain_pkg::*;
#(
  parameter int cfg_words    = 8,
  parameter int period_width = 7
) (
  input  logic                       fw_axi_clk,
  input  logic                       op_code_w_reset,
  input  logic                       exec_strobe,          // Gated execute op-code
  input  sw_word_t                   exec_word,
  input  logic [cfg_words-1:0][15:0] cfg_array,
  input  logic [period_width-1:0]    static_period,
  input  logic                       super_pixel_sel_cfg,
  input  logic [period_width-1:0]    clk_counter,
  input  logic                       gen_clk,
  output logic                       capture_active,
  output logic                       loopback,
  output logic [field_width-1:0]     test_sample,
  output logic                       config_clk,
  output logic                       reset_not,
  output logic                       config_in,
  output logic                       config_load,
  output logic                       super_pixel_sel,
  output logic                       seq_done,
  output logic                       seq_error
);

  localparam int chain_bits = 16 * cfg_words;
  localparam int cnt_width  = $clog2(chain_bits + 1);
  localparam logic [cnt_width-1:0] last_bit = cnt_width'(chain_bits - 1);

  // --------------------
  // Execute decode
  logic [field_width-1:0] ex_delay;
  logic [3:0]             ex_number;
  logic                   start;

  assign ex_delay  = exec_word[ex_delay_lsb +: field_width];
  assign ex_number = exec_word[ex_number_msb:ex_number_lsb];
  assign start     = exec_strobe & (ex_number == chain_test_number);

  logic                   test_enable;  // Chip-side outputs live only for test 1
  logic [field_width-1:0] delay_q;      // Shift point
  logic                   mask_q;

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      test_enable <= 1'b0;
      seq_error   <= 1'b0;
      delay_q     <= '0;
      test_sample <= '0;
      loopback    <= 1'b0;
      mask_q      <= 1'b0;
    end else if (exec_strobe) begin
      test_enable <= start;  // Any other test number turns the outputs off
      if (start) begin
        delay_q     <= ex_delay;
        test_sample <= exec_word[ex_sample_lsb +: field_width];
        loopback    <= exec_word[ex_loopback];
        mask_q      <= exec_word[ex_mask_rst];
        // Too early to settle, or a shift point the counter never reaches
        seq_error   <= (ex_delay < min_delay) | (ex_delay > static_period);
      end
    end
  end

  // --------------------
  // Run FSM
  seq_state_t            state;
  logic [cnt_width-1:0]  shift_cnt;  // Bits already on the chain
  logic [chain_bits-1:0] tx_reg;
  logic                  shifting;
  logic                  advance;

  assign shifting = (state == s_shift_in_0) | (state == s_shift_in);
  assign advance  = shifting & (clk_counter == delay_q);  // Once per config period

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      state     <= s_idle;
      shift_cnt <= '0;
    end else if (start) begin
      state     <= s_delay;  // Restarts from any state
      shift_cnt <= '0;
    end else begin
      case (state)
        s_delay: begin
          if (clk_counter == '0)
            state <= s_reset_not;
        end
        s_reset_not: begin
          if (clk_counter == static_period)  // Last phase, shifting starts at phase 0
            state <= s_shift_in_0;
        end
        s_shift_in_0, s_shift_in: begin
          if (advance) begin
            shift_cnt <= shift_cnt + 1'b1;
            state     <= (shift_cnt == last_bit) ? s_done : s_shift_in;
          end
        end
        default: begin
          state <= state;  // Idle and done wait for a start
        end
      endcase
    end
  end

  // Transmit register, word 0 LSB goes out first
  always_ff @(posedge fw_axi_clk) begin
    if (start)
      tx_reg <= cfg_array;
    else if (advance)
      tx_reg <= {1'b0, tx_reg[chain_bits-1:1]};
  end

  // --------------------
  // Chip-side outputs, all 0 with the test off
  assign capture_active  = test_enable & shifting;
  assign config_clk      = test_enable & shifting & gen_clk;
  assign reset_not       = test_enable & ~((state == s_reset_not) & ~mask_q);
  assign config_in       = test_enable & tx_reg[0];
  assign config_load     = test_enable & ~shifting;  // Low means shift mode in the chip
  assign super_pixel_sel = test_enable & super_pixel_sel_cfg;
  assign seq_done        = (state == s_done);

endmodule

/* rtl/readback_capture.sv */
`timescale 1ns/1ps

module readback_capture
  import chain_pkg::*;
#(
  parameter int cfg_words = 8
) (
  input  logic                    fw_axi_clk,
  input  logic                    op_code_w_reset,
  input  logic                    capture_active,  // Sequencer in a shift state
  input  logic                    loopback,
  input  logic [field_width-1:0]  test_sample,     // Sample phase in the period
  input  logic [field_width-1:0]  clk_counter,
  input  logic                    config_in,       // Local transmit bit
  input  logic                    config_out,      // Bit returning from the chip
  output logic [16*cfg_words-1:0] capture_bits
);

  logic new_bit;
  logic sample;

  assign new_bit = loopback ? config_in : config_out;
  assign sample  = capture_active & (clk_counter == test_sample);

  // First bit sampled ends up at bit 0 after a full run
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset)
      capture_bits <= '0;
    else if (sample)
      capture_bits <= {new_bit, capture_bits[16*cfg_words-1:1]};
  end

endmodule

/* rtl/chain_config_top.sv */
`timescale 1ns/1ps

module chain_config_top
  import host_pkg::*;
  import chain_pkg::*;
#(
  parameter int cfg_words    = 8,  // 16-bit words on the chain
  parameter int period_width = 7
) (
  input  logic       fw_axi_clk,
  input  logic       op_code_w_reset,
  input  logic       dev_id_enable,
  input  logic       op_code_w_cfg_static,
  input  logic       op_code_r_cfg_static,
  input  logic       op_code_w_cfg_array,
  input  logic       op_code_r_cfg_array,
  input  logic       op_code_r_data_array,
  input  logic       op_code_w_status_clear,
  input  logic       op_code_w_execute,
  input  sw_word_t   sw_write24,
  input  logic       config_out,
  output read_word_t read_data32,
  output read_word_t read_status32,
  output logic       config_clk,
  output logic       reset_not,
  output logic       config_in,
  output logic       config_load,
  output logic       super_pixel_sel
);

  // --------------------
  // Internal wires
  logic                       exec_strobe;
  sw_word_t                   exec_word;
  logic [period_width-1:0]    static_period;
  logic                       sps_cfg;  // Static field, before test gating
  logic [cfg_words-1:0][15:0] cfg_array;
  logic [period_width-1:0]    clk_counter;
  logic                       gen_clk;
  logic                       capture_active;
  logic                       loopback;
  logic [field_width-1:0]     test_sample;
  logic                       seq_done;
  logic                       seq_error;
  logic [16*cfg_words-1:0]    capture_bits;

  host_regs #(
    .cfg_words    (cfg_words),
    .period_width (period_width)
  ) u_host_regs (
    .fw_axi_clk             (fw_axi_clk),
    .op_code_w_reset        (op_code_w_reset),
    .dev_id_enable          (dev_id_enable),
    .op_code_w_cfg_static   (op_code_w_cfg_static),
    .op_code_r_cfg_static   (op_code_r_cfg_static),
    .op_code_w_cfg_array    (op_code_w_cfg_array),
    .op_code_r_cfg_array    (op_code_r_cfg_array),
    .op_code_r_data_array   (op_code_r_data_array),
    .op_code_w_status_clear (op_code_w_status_clear),
    .op_code_w_execute      (op_code_w_execute),
    .sw_write24             (sw_write24),
    .seq_done               (seq_done),
    .seq_error              (seq_error),
    .capture_bits           (capture_bits),
    .read_data32            (read_data32),
    .read_status32          (read_status32),
    .exec_strobe            (exec_strobe),
    .exec_word              (exec_word),
    .static_period          (static_period),
    .super_pixel_sel        (sps_cfg),
    .cfg_array              (cfg_array)
  );

  // Runs whenever the device is selected, like the chip clock tree
  config_clk_gen #(
    .period_width (period_width)
  ) u_config_clk_gen (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .enable          (dev_id_enable),
    .period          (static_period),
    .clk_counter     (clk_counter),
    .config_clk      (gen_clk)
  );

  chain_sequencer #(
    .cfg_words    (cfg_words),
    .period_width (period_width)
  ) u_chain_sequencer (
    .fw_axi_clk          (fw_axi_clk),
    .op_code_w_reset     (op_code_w_reset),
    .exec_strobe         (exec_strobe),
    .exec_word           (exec_word),
    .cfg_array           (cfg_array),
    .static_period       (static_period),
    .super_pixel_sel_cfg (sps_cfg),
    .clk_counter         (clk_counter),
    .gen_clk             (gen_clk),
    .capture_active      (capture_active),
    .loopback            (loopback),
    .test_sample         (test_sample),
    .config_clk          (config_clk),
    .reset_not           (reset_not),
    .config_in           (config_in),
    .config_load         (config_load),
    .super_pixel_sel     (super_pixel_sel),
    .seq_done            (seq_done),
    .seq_error           (seq_error)
  );

  readback_capture #(
    .cfg_words (cfg_words)
  ) u_readback_capture (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .capture_active  (capture_active),
    .loopback        (loopback),
    .test_sample     (test_sample),
    .clk_counter     (clk_counter),
    .config_in       (config_in),
    .config_out      (config_out),
    .capture_bits    (capture_bits)
  );

endmodule

/* test/chain_assertions.sv */
`timescale 1ns/1ps

module chain_assertions
  import host_pkg::*;
  import chain_pkg::*;
(
  input logic       fw_axi_clk,
  input logic       op_code_w_reset,
  input logic       exec_strobe,      // Gated execute op-code
  input sw_word_t   exec_word,
  input seq_state_t state,
  input logic       config_clk,
  input logic       reset_not,
  input logic       config_in,
  input logic       config_load,
  input logic       super_pixel_sel
);

  logic shifting;
  logic is_chain_test;
  logic run_on;    // Last execute selected test 1
  logic mask_on;   // Mask bit of the last test 1 execute

  assign shifting      = (state == s_shift_in_0) || (state == s_shift_in);
  assign is_chain_test = (exec_word[ex_number_msb:ex_number_lsb] == chain_test_number);

  // --------------------
  // Expected test enable and mask from the execute stream
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      run_on  <= 1'b0;
      mask_on <= 1'b0;
    end else if (exec_strobe) begin
      run_on <= is_chain_test;  // Any other test number turns the outputs off
      if (is_chain_test)
        mask_on <= exec_word[ex_mask_rst];
    end
  end

  // --------------------
  // Chip-side output rules
  load_low_in_shift: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    run_on |-> (config_load == !shifting))
    else $error("config_load does not follow the shift states");

  mask_holds_reset_not: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    (run_on && mask_on) |-> reset_not)
    else $error("reset_not went low with the mask set");

  outputs_off: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    !run_on |-> ({config_clk, reset_not, config_in, config_load, super_pixel_sel} == 5'b0))
    else $error("Chip-side outputs active with the test disabled");

endmodule

bind chain_sequencer chain_assertions u_chain_assertions (
  .fw_axi_clk      (fw_axi_clk),
  .op_code_w_reset (op_code_w_reset),
  .exec_strobe     (exec_strobe),
  .exec_word       (exec_word),
  .state           (state),
  .config_clk      (config_clk),
  .reset_not       (reset_not),
  .config_in       (config_in),
  .config_load     (config_load),
  .super_pixel_sel (super_pixel_sel)
);

/* test/tb_chain_config.sv */
`timescale 1ns/1ps

module tb_chain_config
  import host_pkg::*;
  import chain_pkg::*;
();

  localparam int cfg_words       = 8;
  localparam int period_width    = 7;
  localparam int clk_period      = 20;
  localparam int run_cycles      = 130 * 16;             // Longest run at period 15
  localparam int watchdog_cycles = 4 * run_cycles + 2000;

  // Strobe vector index per op-code
  localparam int op_w_static = 0;
  localparam int op_r_static = 1;
  localparam int op_w_array  = 2;
  localparam int op_r_array  = 3;
  localparam int op_r_data   = 4;
  localparam int op_clear    = 5;
  localparam int op_exec     = 6;

  logic       fw_axi_clk;
  logic       op_code_w_reset;
  logic       dev_id_enable;
  logic [6:0] strobes;           // One-hot op-code strobes
  sw_word_t   sw_write24;
  logic       config_out;
  read_word_t read_data32;
  read_word_t read_status32;
  logic       config_clk;
  logic       reset_not;
  logic       config_in;
  logic       config_load;
  logic       super_pixel_sel;

  // --------------------
  // Reference model
  logic [15:0] model_array [cfg_words];
  sw_word_t    model_static;
  read_word_t  model_sticky;      // Op-code bits of the status word
  logic [31:0] rng_state;
  int          errors;
  int          checks;

  assign config_out = ~config_in;  // Chip model inverts the chain

  chain_config_top #(
    .cfg_words    (cfg_words),
    .period_width (period_width)
  ) uut (
    .fw_axi_clk             (fw_axi_clk),
    .op_code_w_reset        (op_code_w_reset),
    .dev_id_enable          (dev_id_enable),
    .op_code_w_cfg_static   (strobes[op_w_static]),
    .op_code_r_cfg_static   (strobes[op_r_static]),
    .op_code_w_cfg_array    (strobes[op_w_array]),
    .op_code_r_cfg_array    (strobes[op_r_array]),
    .op_code_r_data_array   (strobes[op_r_data]),
    .op_code_w_status_clear (strobes[op_clear]),
    .op_code_w_execute      (strobes[op_exec]),
    .sw_write24             (sw_write24),
    .config_out             (config_out),
    .read_data32            (read_data32),
    .read_status32          (read_status32),
    .config_clk             (config_clk),
    .reset_not              (reset_not),
    .config_in              (config_in),
    .config_load            (config_load),
    .super_pixel_sel        (super_pixel_sel)
  );

  initial fw_axi_clk = 1'b0;
  always #(clk_period / 2) fw_axi_clk = ~fw_axi_clk;

  // --------------------
  // Helpers
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int rand_below(input int n);
    return int'(xorshift32() % n);
  endfunction

  function automatic logic [15:0] model_word(input int idx);
    if (idx < cfg_words)
      return model_array[idx];
    return 16'h0000;  // Past the array
  endfunction

  // Expected readback word a, chip inverts unless loopback
  function automatic logic [31:0] capture_word(input int a, input bit invert);
    logic [31:0] w;
    if (a >= cfg_words / 2)
      return 32'h0;
    w = {model_array[2*a+1], model_array[2*a]};
    return invert ? ~w : w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // One-cycle strobe, returns on the falling edge after it took effect
  task automatic issue_op(input int op, input sw_word_t word);
    int addr;
    addr = int'(word[addr_msb:addr_lsb]);
    @(negedge fw_axi_clk);
    sw_write24  = word;
    strobes[op] = 1'b1;
    @(negedge fw_axi_clk);
    strobes = '0;
    if (dev_id_enable) begin
      case (op)
        op_w_static: begin
          model_static = word;
          model_sticky[st_w_cfg_static] = 1'b1;
        end
        op_w_array: begin
          if (addr < cfg_words)
            model_array[addr] = word[data_msb:data_lsb];
          model_sticky[st_w_cfg_array] = 1'b1;
        end
        op_r_static: model_sticky[st_r_cfg_static] = 1'b1;
        op_r_array:  model_sticky[st_r_cfg_array]  = 1'b1;
        op_r_data:   model_sticky[st_r_data_array] = 1'b1;
        op_exec:     model_sticky[st_w_execute]    = 1'b1;
        default:     model_sticky = '0;              // Status clear
      endcase
    end
  endtask

  task automatic check_status(input bit done, input bit err);
    read_word_t exp;
    exp = model_sticky;
    exp[st_done]  = done;
    exp[st_error] = err;
    check_value("read_status32", exp, read_status32);
  endtask

  task automatic apply_reset();
    @(negedge fw_axi_clk);
    op_code_w_reset = 1'b1;
    repeat (2) @(negedge fw_axi_clk);
    op_code_w_reset = 1'b0;
    model_static = '0;
    model_sticky = 32'h1;  // Reset sets its own bit
    for (int i = 0; i < cfg_words; i++)
      model_array[i] = 16'h0000;
  endtask

  task automatic read_array_check(input int a);
    issue_op(op_r_array, {8'(a), 16'h0000});
    check_value("read_data32 (array)", {model_word(a + 1), model_word(a)}, read_data32);
  endtask

  // --------------------
  // Chain run, loopback or through the chip model
  task automatic run_chain(input bit lb);
    logic [31:0] r;
    int          period;
    int          delay;
    int          sample;
    int          cycles;
    bit          sps;
    bit          mask;
    sw_word_t    word;
    for (int i = 0; i < cfg_words; i++) begin
      r = xorshift32();
      issue_op(op_w_array, {8'(i), r[15:0]});
    end
    r      = xorshift32();
    period = 4 + rand_below(12);            // 4 to 15
    sps    = r[0];
    mask   = r[1];
    issue_op(op_w_static, {r[31:16], sps, 7'(period)});
    delay  = 3 + rand_below(period - 2);    // 3 to period
    sample = rand_below(delay);             // Before the shift point
    word   = {mask, 4'b0000, lb, chain_test_number, 7'(sample), 7'(delay)};
    issue_op(op_exec, word);
    check_value("super_pixel_sel", 32'(sps), 32'(super_pixel_sel));
    repeat (2) @(negedge fw_axi_clk);       // Old done bit drains
    cycles = 0;
    while (read_status32[st_done] == 1'b0 && cycles < run_cycles + 64) begin
      @(negedge fw_axi_clk);
      cycles++;
    end
    if (read_status32[st_done] == 1'b0) begin
      $display("Chain run did not reach done within %0d cycles", cycles);
      errors++;
    end
    check_value("config_load", 32'h1, 32'(config_load));  // Back in load mode
    check_value("config_clk", 32'h0, 32'(config_clk));
    check_status(1'b1, 1'b0);
    for (int a = 0; a < cfg_words / 2; a++) begin
      issue_op(op_r_data, {8'(a), 16'h0000});
      check_value("read_data32 (data)", capture_word(a, !lb), read_data32);
    end
    issue_op(op_r_data, {8'(cfg_words / 2 + rand_below(200)), 16'h0000});
    check_value("read_data32 (data out of range)", 32'h0, read_data32);
    check_status(1'b1, 1'b0);
  endtask

  // --------------------
  // Main sequence
  initial begin
    logic [31:0] r;
    int          a;
    op_code_w_reset = 1'b1;
    dev_id_enable   = 1'b1;
    strobes         = '0;
    sw_write24      = '0;
    rng_state       = 32'hc38f_7aff;
    errors          = 0;
    checks          = 0;
    model_static    = '0;
    model_sticky    = 32'h1;
    for (int i = 0; i < cfg_words; i++)
      model_array[i] = 16'h0000;
    repeat (2) @(negedge fw_axi_clk);
    op_code_w_reset = 1'b0;
    check_status(1'b0, 1'b0);

    // Register round trip
    for (int n = 0; n < 6; n++) begin
      r = xorshift32();
      issue_op(op_w_static, r[23:0]);
      issue_op(op_r_static, 24'h0);
      check_value("read_data32 (static)", {8'h00, model_static}, read_data32);
      for (int i = 0; i < cfg_words; i++) begin
        r = xorshift32();
        issue_op(op_w_array, {8'(i), r[15:0]});
      end
      r = xorshift32();
      issue_op(op_w_array, {8'(cfg_words + rand_below(200)), r[15:0]});  // Dropped
      for (int k = 0; k < 4; k++)
        read_array_check(rand_below(cfg_words + 2));
      read_array_check(cfg_words - 1);   // Upper half past the array
      read_array_check(255);
    end
    check_status(1'b0, 1'b0);

    // Device gating
    dev_id_enable = 1'b0;
    r = xorshift32();
    issue_op(op_w_static, r[23:0]);
    issue_op(op_w_array, {8'h00, r[31:16]});
    issue_op(op_exec, {6'b000000, chain_test_number, 14'h0183});
    issue_op(op_clear, 24'h0);
    check_status(1'b0, 1'b0);
    check_value("config_load", 32'h0, 32'(config_load));  // Test never enabled
    dev_id_enable = 1'b1;
    issue_op(op_r_static, 24'h0);
    check_value("read_data32 (static)", {8'h00, model_static}, read_data32);
    read_array_check(0);
    check_status(1'b0, 1'b0);

    run_chain(1'b1);
    run_chain(1'b0);

    // Settings error, then reset and status
    issue_op(op_w_static, {16'h0000, 1'b1, 7'd8});
    issue_op(op_exec, {6'b000010, chain_test_number, 7'd0, 7'(rand_below(3))});
    repeat (2) @(negedge fw_axi_clk);
    check_status(1'b0, 1'b1);
    apply_reset();
    check_value("config_clk", 32'h0, 32'(config_clk));
    check_value("reset_not", 32'h0, 32'(reset_not));
    check_value("config_in", 32'h0, 32'(config_in));
    check_value("config_load", 32'h0, 32'(config_load));
    check_value("super_pixel_sel", 32'h0, 32'(super_pixel_sel));
    check_value("read_data32", 32'h0, read_data32);
    check_status(1'b0, 1'b0);
    issue_op(op_r_static, 24'h0);
    check_value("read_data32 (static)", 32'h0, read_data32);
    r = xorshift32();
    a = rand_below(cfg_words);
    issue_op(op_w_array, {8'(a), r[15:0]});
    read_array_check(a);
    issue_op(op_r_data, 24'h0);
    check_value("read_data32 (data)", 32'h0, read_data32);  // Capture cleared
    check_status(1'b0, 1'b0);
    issue_op(op_clear, 24'h0);
    check_value("read_status32", 32'h0, read_status32);
    @(negedge fw_axi_clk);
    check_value("read_status32", 32'h0, read_status32);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout: simulation ran past %0d cycles", watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* files.f */
rtl/host_pkg.sv
rtl/chain_pkg.sv
rtl/host_regs.sv
rtl/config_clk_gen.sv
rtl/chain_sequencer.sv
rtl/readback_capture.sv
rtl/chain_config_top.sv
test/chain_assertions.sv
test/tb_chain_config.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_chain_config \
  -o sim_chain_config
./obj_dir/sim_chain_config > sim.log 2>&1
cat sim.log

if grep -qx "TEST OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
